//--- logic/axi_link_consts.svh
/*
 * AXI field widths, PHY lane width, credit width and channel FIFO depths
 * for the write-side link bridge
 */
`ifndef AXI_LINK_CONSTS_SVH
`define AXI_LINK_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// AXI fields
`define AXI_ID_W     4
`define AXI_ADDR_W   32
`define AXI_DATA_W   32
`define AXI_LEN_W    8
`define AXI_SIZE_W   3
`define AXI_BURST_W  2
`define AXI_RESP_W   2

//////////////////////////////////////////////////////////////////////
// Link side

// One PHY lane word
`define PHY_LANE_W   80

// Credit counters and init credit inputs
`define CRED_W       8

// Channel FIFOs
`define TX_FIFO_DEPTH  2
`define B_FIFO_DEPTH   8

`endif

//--- logic/axi_link_pkg.sv
/*
 * Derived channel payload widths and the bit positions
 * of each channel inside the TX and RX lane words
 */
`include "axi_link_consts.svh"

package axi_link_pkg;

  // Write strobe, one bit per data byte
  localparam int STRB_W = `AXI_DATA_W / 8;

  // Payload widths, fields packed MSB first
  // AW: id, size, len, burst, addr
  localparam int AW_PAYLOAD_W = `AXI_ID_W + `AXI_SIZE_W + `AXI_LEN_W +
                                `AXI_BURST_W + `AXI_ADDR_W;
  // W: id, data, strb, last
  localparam int W_PAYLOAD_W  = `AXI_ID_W + `AXI_DATA_W + STRB_W + 1;
  // B: id, resp
  localparam int B_PAYLOAD_W  = `AXI_ID_W + `AXI_RESP_W;

  // TX lane 0 layout
  localparam int TX0_AW_PUSH = 0;
  localparam int TX0_W_PUSH  = 1;
  localparam int TX0_B_CRED  = 2;
  localparam int TX0_AW_LSB  = 3;

  // TX lane 1 carries the W payload only
  localparam int TX1_W_LSB   = 0;

  // RX lane 0 layout
  localparam int RX0_B_PUSH  = 0;
  localparam int RX0_AW_CRED = 1;
  localparam int RX0_W_CRED  = 2;
  localparam int RX0_B_LSB   = 3;

endpackage

//--- logic/sync_fifo.sv
/*
 * Synchronous register-array FIFO with occupancy count,
 * head entry shown on rd_data
 */
`include "axi_link_consts.svh"

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = `TX_FIFO_DEPTH
) (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // Requests beyond the limits are ignored
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  assign rd_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk_wr) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and count
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/link_ctrl.sv
/*
 * Link bring-up: qualifies tx_online and rx_online over two stages,
 * raises link_up and pulses credit_load as the link comes up
 */
`include "axi_link_consts.svh"

module link_ctrl
  import axi_link_pkg::*;
(
  input  logic clk_wr,
  input  logic arst_n,
  input  logic tx_online,
  input  logic rx_online,
  output logic link_up,
  output logic credit_load
);

  logic both_online;
  logic qual_q;

  assign both_online = tx_online & rx_online;

  //////////////////////////////////////////////////////////////////////
  // Two-stage qualify
  // Any drop of either input clears both stages at once, so link_up
  // falls one cycle after the drop
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      qual_q      <= 1'b0;
      link_up     <= 1'b0;
      credit_load <= 1'b0;
    end else if (!both_online) begin
      qual_q      <= 1'b0;
      link_up     <= 1'b0;
      credit_load <= 1'b0;
    end else begin
      qual_q      <= 1'b1;
      link_up     <= qual_q;
      // Rising edge of link_up, loads every credit counter together
      credit_load <= qual_q & ~link_up;
    end
  end

endmodule

//--- logic/tx_channel.sv
/*
 * Transmit channel: user FIFO, credit counter and push strobe
 * toward the PHY framer
 */
`include "axi_link_consts.svh"

module tx_channel
  import axi_link_pkg::*;
#(
  parameter int WIDTH = AW_PAYLOAD_W
) (
  input  logic               clk_wr,
  input  logic               arst_n,
  input  logic               link_up,
  input  logic               credit_load,
  input  logic [`CRED_W-1:0] init_credit,
  input  logic               user_valid,
  input  logic [WIDTH-1:0]   user_data,
  output logic               user_ready,
  input  logic               credit_in,
  output logic               push,
  output logic [WIDTH-1:0]   push_data
);

  logic [`CRED_W-1:0] credit_cnt;
  logic               fifo_full;
  logic               fifo_empty;

  // Ready follows FIFO room only, the link state does not matter here
  assign user_ready = ~fifo_full;

  // Head leaves as a push while the link is up and a credit remains
  assign push = link_up & (credit_cnt != '0) & ~fifo_empty;

  sync_fifo #(
    .WIDTH (WIDTH),
    .DEPTH (`TX_FIFO_DEPTH)
  ) fifo_i (
    .clk_wr  (clk_wr),
    .arst_n  (arst_n),
    .wr_en   (user_valid & user_ready),
    .wr_data (user_data),
    .rd_en   (push),
    .rd_data (push_data),
    .full    (fifo_full),
    .empty   (fifo_empty)
  );

  //////////////////////////////////////////////////////////////////////
  // Credit counter
  // Load wins; credits are forgotten while the link is down so a new
  // bring-up always starts from init_credit
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= '0;
    end else if (credit_load) begin
      credit_cnt <= init_credit;
    end else if (!link_up) begin
      credit_cnt <= '0;
    end else begin
      case ({push, credit_in})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        // Push and return in one cycle cancel out
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

//--- logic/rx_channel.sv
/*
 * Receive channel: stores far-end pushes in a FIFO,
 * presents them with valid/ready and returns a credit per pop
 */
`include "axi_link_consts.svh"

module rx_channel
  import axi_link_pkg::*;
#(
  parameter int WIDTH = B_PAYLOAD_W,
  parameter int DEPTH = `B_FIFO_DEPTH
) (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             user_valid,
  output logic [WIDTH-1:0] user_data,
  input  logic             user_ready,
  output logic             credit_out
);

  logic fifo_empty;
  logic pop;

  assign user_valid = ~fifo_empty;
  assign pop        = user_valid & user_ready;

  // Far end holds our credits, so a push never finds the FIFO full
  sync_fifo #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) fifo_i (
    .clk_wr  (clk_wr),
    .arst_n  (arst_n),
    .wr_en   (push),
    .wr_data (push_data),
    .rd_en   (pop),
    .rd_data (user_data),
    .full    (),
    .empty   (fifo_empty)
  );

  //////////////////////////////////////////////////////////////////////
  // Credit return
  // One pulse per pop, a cycle after the handshake
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      credit_out <= 1'b0;
    end else begin
      credit_out <= pop;
    end
  end

endmodule

//--- logic/phy_framer.sv
/*
 * PHY framing: registered TX lane words built from channel pushes
 * and credits, combinational slicing of the RX lane word
 */
`include "axi_link_consts.svh"

module phy_framer
  import axi_link_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   arst_n,
  input  logic                   link_up,

  // Transmit side
  input  logic                   aw_push,
  input  logic [AW_PAYLOAD_W-1:0] aw_data,
  input  logic                   w_push,
  input  logic [W_PAYLOAD_W-1:0] w_data,
  input  logic                   b_credit,
  output logic [`PHY_LANE_W-1:0] tx_phy0,
  output logic [`PHY_LANE_W-1:0] tx_phy1,

  // Receive side
  input  logic [`PHY_LANE_W-1:0] rx_phy0,
  output logic                   b_push,
  output logic [B_PAYLOAD_W-1:0] b_data,
  output logic                   aw_credit,
  output logic                   w_credit
);

  logic [`PHY_LANE_W-1:0] lane0_next;
  logic [`PHY_LANE_W-1:0] lane1_next;

  //////////////////////////////////////////////////////////////////////
  // TX lane assembly
  // Payload bits stay zero unless the matching push is set
  always_comb begin
    lane0_next = '0;
    lane1_next = '0;
    lane0_next[TX0_AW_PUSH] = aw_push;
    lane0_next[TX0_W_PUSH]  = w_push;
    lane0_next[TX0_B_CRED]  = b_credit;
    if (aw_push) begin
      lane0_next[TX0_AW_LSB +: AW_PAYLOAD_W] = aw_data;
    end
    if (w_push) begin
      lane1_next[TX1_W_LSB +: W_PAYLOAD_W] = w_data;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (!link_up) begin
      // Idle lanes while the link is down
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= lane0_next;
      tx_phy1 <= lane1_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // RX lane decode
  assign b_push    = link_up & rx_phy0[RX0_B_PUSH];
  assign aw_credit = link_up & rx_phy0[RX0_AW_CRED];
  assign w_credit  = link_up & rx_phy0[RX0_W_CRED];
  assign b_data    = link_up ? rx_phy0[RX0_B_LSB +: B_PAYLOAD_W] : '0;

endmodule

//--- logic/axi_wr_master_top.sv
/*
 * Write-side AXI master bridge top: AW/W transmit channels, B receive
 * channel, link control and PHY lane framing
 */
`include "axi_link_consts.svh"

module axi_wr_master_top
  import axi_link_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    arst_n,

  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic [`CRED_W-1:0]      init_aw_credit,
  input  logic [`CRED_W-1:0]      init_w_credit,

  // PHY lanes
  output logic [`PHY_LANE_W-1:0]  tx_phy0,
  output logic [`PHY_LANE_W-1:0]  tx_phy1,
  input  logic [`PHY_LANE_W-1:0]  rx_phy0,

  // AW channel
  input  logic [`AXI_ID_W-1:0]    user_awid,
  input  logic [`AXI_SIZE_W-1:0]  user_awsize,
  input  logic [`AXI_LEN_W-1:0]   user_awlen,
  input  logic [`AXI_BURST_W-1:0] user_awburst,
  input  logic [`AXI_ADDR_W-1:0]  user_awaddr,
  input  logic                    user_awvalid,
  output logic                    user_awready,

  // W channel
  input  logic [`AXI_ID_W-1:0]    user_wid,
  input  logic [`AXI_DATA_W-1:0]  user_wdata,
  input  logic [STRB_W-1:0]       user_wstrb,
  input  logic                    user_wlast,
  input  logic                    user_wvalid,
  output logic                    user_wready,

  // B channel
  output logic [`AXI_ID_W-1:0]    user_bid,
  output logic [`AXI_RESP_W-1:0]  user_bresp,
  output logic                    user_bvalid,
  input  logic                    user_bready
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  logic                    link_up;
  logic                    credit_load;

  logic [AW_PAYLOAD_W-1:0] aw_user_data;
  logic [AW_PAYLOAD_W-1:0] aw_push_data;
  logic                    aw_push;
  logic                    aw_credit;

  logic [W_PAYLOAD_W-1:0]  w_user_data;
  logic [W_PAYLOAD_W-1:0]  w_push_data;
  logic                    w_push;
  logic                    w_credit;

  logic [B_PAYLOAD_W-1:0]  b_user_data;
  logic [B_PAYLOAD_W-1:0]  b_push_data;
  logic                    b_push;
  logic                    b_credit;

  // Field packing, MSB first
  assign aw_user_data = {user_awid, user_awsize, user_awlen, user_awburst, user_awaddr};
  assign w_user_data  = {user_wid, user_wdata, user_wstrb, user_wlast};
  assign {user_bid, user_bresp} = b_user_data;

  //////////////////////////////////////////////////////////////////////
  // Link control
  link_ctrl link_ctrl_i (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .tx_online   (tx_online),
    .rx_online   (rx_online),
    .link_up     (link_up),
    .credit_load (credit_load)
  );

  //////////////////////////////////////////////////////////////////////
  // Channels
  tx_channel #(.WIDTH(AW_PAYLOAD_W)) aw_tx_i (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .link_up     (link_up),
    .credit_load (credit_load),
    .init_credit (init_aw_credit),
    .user_valid  (user_awvalid),
    .user_data   (aw_user_data),
    .user_ready  (user_awready),
    .credit_in   (aw_credit),
    .push        (aw_push),
    .push_data   (aw_push_data)
  );

  tx_channel #(.WIDTH(W_PAYLOAD_W)) w_tx_i (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .link_up     (link_up),
    .credit_load (credit_load),
    .init_credit (init_w_credit),
    .user_valid  (user_wvalid),
    .user_data   (w_user_data),
    .user_ready  (user_wready),
    .credit_in   (w_credit),
    .push        (w_push),
    .push_data   (w_push_data)
  );

  rx_channel #(.WIDTH(B_PAYLOAD_W), .DEPTH(`B_FIFO_DEPTH)) b_rx_i (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .push        (b_push),
    .push_data   (b_push_data),
    .user_valid  (user_bvalid),
    .user_data   (b_user_data),
    .user_ready  (user_bready),
    .credit_out  (b_credit)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY framing
  phy_framer framer_i (
    .clk_wr    (clk_wr),
    .arst_n    (arst_n),
    .link_up   (link_up),
    .aw_push   (aw_push),
    .aw_data   (aw_push_data),
    .w_push    (w_push),
    .w_data    (w_push_data),
    .b_credit  (b_credit),
    .tx_phy0   (tx_phy0),
    .tx_phy1   (tx_phy1),
    .rx_phy0   (rx_phy0),
    .b_push    (b_push),
    .b_data    (b_push_data),
    .aw_credit (aw_credit),
    .w_credit  (w_credit)
  );

endmodule

//--- test/axi_wr_master_props.sv
/*
 * Concurrent checks on the transmit channel for pushes only with the
 * link up, no credit underflow and ready low while the FIFO is full
 */
`include "axi_link_consts.svh"

module axi_wr_master_props (
  input logic               clk_wr,
  input logic               arst_n,
  input logic               link_up,
  input logic               credit_load,
  input logic               push,
  input logic [`CRED_W-1:0] credit_cnt,
  input logic               user_valid,
  input logic               user_ready
);

  localparam int OCC_W = $clog2(`TX_FIFO_DEPTH + 1);

  // Items taken from the user and not yet pushed
  logic [OCC_W-1:0] occ;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      occ <= '0;
    end else begin
      case ({user_valid & user_ready, push})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  // The counter is still empty in the cycle link_up rises
  push_needs_link: assert property (@(posedge clk_wr) disable iff (!arst_n)
    push |-> (link_up && $past(link_up)))
    else $error("push raised while link_up is low");

  // A push from an empty counter would wrap it to all ones
  credit_no_wrap: assert property (@(posedge clk_wr) disable iff (!arst_n)
    ((credit_cnt == '0) && !credit_load) |=> (credit_cnt <= `CRED_W'(1)))
    else $error("credit count wrapped below zero");

  ready_low_when_full: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (occ == OCC_W'(`TX_FIFO_DEPTH)) |-> !user_ready)
    else $error("user_ready high while the FIFO is full");

endmodule

bind tx_channel axi_wr_master_props props_i (
  .clk_wr      (clk_wr),
  .arst_n      (arst_n),
  .link_up     (link_up),
  .credit_load (credit_load),
  .push        (push),
  .credit_cnt  (credit_cnt),
  .user_valid  (user_valid),
  .user_ready  (user_ready)
);

//--- test/tb_axi_wr_master.sv
/*
 * Testbench for the write-side AXI link bridge: LFSR stimulus,
 * far-end link model, lane and B channel checks, watchdog
 */
`include "axi_link_consts.svh"

module tb_axi_wr_master
  import axi_link_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_TXN      = 40;
  localparam int SETTLE_CYC   = 40;
  localparam int INIT_CRED    = 3;
  localparam int WATCHDOG_CYC = 200 * NUM_TXN;

  logic                    clk_wr = 1'b0;
  logic                    arst_n;
  logic                    tx_online;
  logic                    rx_online;
  logic [`CRED_W-1:0]      init_aw_credit;
  logic [`CRED_W-1:0]      init_w_credit;
  logic [`PHY_LANE_W-1:0]  tx_phy0;
  logic [`PHY_LANE_W-1:0]  tx_phy1;
  logic [`PHY_LANE_W-1:0]  rx_phy0;
  logic [`AXI_ID_W-1:0]    user_awid;
  logic [`AXI_SIZE_W-1:0]  user_awsize;
  logic [`AXI_LEN_W-1:0]   user_awlen;
  logic [`AXI_BURST_W-1:0] user_awburst;
  logic [`AXI_ADDR_W-1:0]  user_awaddr;
  logic                    user_awvalid;
  logic                    user_awready;
  logic [`AXI_ID_W-1:0]    user_wid;
  logic [`AXI_DATA_W-1:0]  user_wdata;
  logic [STRB_W-1:0]       user_wstrb;
  logic                    user_wlast;
  logic                    user_wvalid;
  logic                    user_wready;
  logic [`AXI_ID_W-1:0]    user_bid;
  logic [`AXI_RESP_W-1:0]  user_bresp;
  logic                    user_bvalid;
  logic                    user_bready;

  // Stimulus controls, changed on the rising edge only
  bit tx_req, rx_req, traffic_en, hold_valid, ret_en, bsend_en;

  // Far-end and scoreboard state
  logic [AW_PAYLOAD_W-1:0] aw_exp[$];
  logic [W_PAYLOAD_W-1:0]  w_exp[$];
  logic [B_PAYLOAD_W-1:0]  b_exp[$];
  logic [31:0]             lfsr_q = 32'h24251762;
  int  val_errs = 0, oth_errs = 0;
  int  aw_acc = 0, w_acc = 0, aw_sess = 0, w_sess = 0;
  int  aw_owed = 0, w_owed = 0, b_avail = `B_FIFO_DEPTH;
  int  up_cnt = 0, down_cnt = 0;
  bit  aw_took, w_took, hs_d1, hs_d2, b_lat_chk, awready_s, wready_s;

  axi_wr_master_top dut_i (.*);

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  //////////////////////////////////////////////////////////////////////
  // Random numbers, 32-bit Fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_wr);
  endtask

  task automatic track_link();
    if (tx_online && rx_online) begin
      up_cnt++;
      down_cnt = 0;
    end else begin
      down_cnt++;
      up_cnt = 0;
    end
    // New session, the DUT reloads its initial credits
    if (up_cnt == 1) begin
      aw_owed = 0;
      w_owed  = 0;
      aw_sess = 0;
      w_sess  = 0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // TX lane checks
  task automatic check_lanes();
    logic [AW_PAYLOAD_W-1:0] exp_aw;
    logic [W_PAYLOAD_W-1:0]  exp_w;
    if (down_cnt >= 2 && (tx_phy0 != '0 || tx_phy1 != '0)) begin
      oth_errs++;
      $display("At %0t the TX lanes are not idle although the link is down", $time);
    end
    if (tx_phy0[`PHY_LANE_W-1:TX0_AW_LSB+AW_PAYLOAD_W] != '0 ||
        tx_phy1[`PHY_LANE_W-1:TX1_W_LSB+W_PAYLOAD_W] != '0) begin
      oth_errs++;
      $display("At %0t unused TX lane bits are set", $time);
    end
    if (tx_phy0[TX0_AW_PUSH]) begin
      aw_owed++;
      aw_sess++;
      if (aw_exp.size() == 0) begin
        oth_errs++;
        $display("At %0t an AW push arrived with no accepted AW item left", $time);
      end else begin
        exp_aw = aw_exp.pop_front();
        if (tx_phy0[TX0_AW_LSB +: AW_PAYLOAD_W] !== exp_aw) begin
          val_errs++;
          $display("[ERROR] %0t: AW payload %h, expected %h", $time,
                   tx_phy0[TX0_AW_LSB +: AW_PAYLOAD_W], exp_aw);
        end
      end
    end else if (tx_phy0[TX0_AW_LSB +: AW_PAYLOAD_W] != '0) begin
      oth_errs++;
      $display("At %0t AW payload bits are set without an AW push", $time);
    end
    if (tx_phy0[TX0_W_PUSH]) begin
      w_owed++;
      w_sess++;
      if (w_exp.size() == 0) begin
        oth_errs++;
        $display("At %0t a W push arrived with no accepted W beat left", $time);
      end else begin
        exp_w = w_exp.pop_front();
        if (tx_phy1[TX1_W_LSB +: W_PAYLOAD_W] !== exp_w) begin
          val_errs++;
          $display("[ERROR] %0t: W payload %h, expected %h", $time,
                   tx_phy1[TX1_W_LSB +: W_PAYLOAD_W], exp_w);
        end
      end
    end else if (tx_phy1 != '0) begin
      oth_errs++;
      $display("At %0t lane 1 carries data without a W push", $time);
    end
    // B credit bit two cycles after the handshake
    if (tx_phy0[TX0_B_CRED] !== hs_d2) begin
      val_errs++;
      $display("[ERROR] %0t: B credit bit %0b, expected %0b", $time,
               tx_phy0[TX0_B_CRED], hs_d2);
    end
    if (tx_phy0[TX0_B_CRED]) begin
      b_avail++;
    end
    if (b_avail > `B_FIFO_DEPTH) begin
      oth_errs++;
      $display("At %0t more B credits came back than B words were sent", $time);
    end
    hs_d2 = hs_d1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // User side, valid held until taken
  task automatic drive_user();
    tx_online = tx_req;
    rx_online = rx_req;
    if (!user_awvalid || aw_took) begin
      user_awvalid = traffic_en && (hold_valid || rand_bits(1) != 0);
      if (user_awvalid) begin
        user_awid    = `AXI_ID_W'(rand_bits(`AXI_ID_W));
        user_awsize  = `AXI_SIZE_W'(rand_bits(`AXI_SIZE_W));
        user_awlen   = `AXI_LEN_W'(rand_bits(`AXI_LEN_W));
        user_awburst = `AXI_BURST_W'(rand_bits(`AXI_BURST_W));
        user_awaddr  = rand_bits(`AXI_ADDR_W);
      end
    end
    if (!user_wvalid || w_took) begin
      user_wvalid = traffic_en && (hold_valid || rand_bits(1) != 0);
      if (user_wvalid) begin
        user_wid   = `AXI_ID_W'(rand_bits(`AXI_ID_W));
        user_wdata = rand_bits(`AXI_DATA_W);
        user_wstrb = STRB_W'(rand_bits(STRB_W));
        user_wlast = 1'(rand_bits(1));
      end
    end
    // Ready only moves on the rising edge, so these are the taking values
    awready_s = user_awready;
    wready_s  = user_wready;
    aw_took   = user_awvalid && user_awready;
    w_took    = user_wvalid && user_wready;
    if (aw_took) begin
      aw_exp.push_back({user_awid, user_awsize, user_awlen, user_awburst, user_awaddr});
      aw_acc++;
    end
    if (w_took) begin
      w_exp.push_back({user_wid, user_wdata, user_wstrb, user_wlast});
      w_acc++;
    end
  endtask

  task automatic take_b();
    logic [B_PAYLOAD_W-1:0] exp_b;
    user_bready = 1'(rand_bits(1));
    hs_d1 = user_bvalid && user_bready;
    if (hs_d1) begin
      if (b_exp.size() == 0) begin
        oth_errs++;
        $display("At %0t a B handshake happened with no B word sent", $time);
      end else begin
        exp_b = b_exp.pop_front();
        if ({user_bid, user_bresp} !== exp_b) begin
          val_errs++;
          $display("[ERROR] %0t: B response %h, expected %h", $time,
                   {user_bid, user_bresp}, exp_b);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Far end: credit returns and B words on the RX lane
  task automatic far_end();
    logic [B_PAYLOAD_W-1:0] b_word;
    rx_phy0 = '0;
    if (ret_en && up_cnt >= 3) begin
      if (aw_owed > 0 && rand_bits(1) != 0) begin
        rx_phy0[RX0_AW_CRED] = 1'b1;
        aw_owed--;
      end
      if (w_owed > 0 && rand_bits(1) != 0) begin
        rx_phy0[RX0_W_CRED] = 1'b1;
        w_owed--;
      end
    end
    if (bsend_en && up_cnt >= 3 && b_avail > 0 && rand_bits(1) != 0) begin
      b_word = B_PAYLOAD_W'(rand_bits(B_PAYLOAD_W));
      rx_phy0[RX0_B_PUSH] = 1'b1;
      rx_phy0[RX0_B_LSB +: B_PAYLOAD_W] = b_word;
      // Into an empty channel, bvalid must follow one cycle later
      if (b_exp.size() == 0) begin
        b_lat_chk = 1'b1;
      end
      b_exp.push_back(b_word);
      b_avail--;
    end
  endtask

  always @(negedge clk_wr) begin
    track_link();
    check_lanes();
    if (b_lat_chk && !user_bvalid) begin
      oth_errs++;
      $display("At %0t bvalid did not rise one cycle after a B word arrived", $time);
    end
    b_lat_chk = 1'b0;
    drive_user();
    take_b();
    far_end();
  end

  task automatic check_stall();
    if (aw_sess != INIT_CRED || w_sess != INIT_CRED) begin
      oth_errs++;
      $display("Without credit returns %0d AW and %0d W pushes went out, not %0d each",
               aw_sess, w_sess, INIT_CRED);
    end
    if (awready_s || wready_s || aw_exp.size() != 2 || w_exp.size() != 2) begin
      oth_errs++;
      $display("Stalled channels did not fill their FIFOs and drop ready");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  initial begin
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_aw_credit = `CRED_W'(INIT_CRED);
    init_w_credit  = `CRED_W'(INIT_CRED);
    rx_phy0        = '0;
    user_awvalid   = 1'b0;
    {user_awid, user_awsize, user_awlen, user_awburst, user_awaddr} = '0;
    user_wvalid    = 1'b0;
    {user_wid, user_wdata, user_wstrb, user_wlast} = '0;
    user_bready    = 1'b0;
    repeat (2) @(posedge clk_wr);
    @(negedge clk_wr);
    arst_n = 1'b1;
    // Only tx_online up, items may be taken but must stay put
    @(posedge clk_wr);
    tx_req     = 1'b1;
    traffic_en = 1'b1;
    wait_cycles(20);
    rx_req     = 1'b1;
    hold_valid = 1'b1;
    wait_cycles(SETTLE_CYC);
    check_stall();
    hold_valid = 1'b0;
    ret_en     = 1'b1;
    bsend_en   = 1'b1;
    while (aw_acc < NUM_TXN / 2) @(posedge clk_wr);
    // Empty the B channel before the link goes away
    bsend_en = 1'b0;
    while (b_exp.size() != 0 || b_avail != `B_FIFO_DEPTH) @(posedge clk_wr);
    tx_req = 1'b0;
    wait_cycles(10);
    ret_en     = 1'b0;
    hold_valid = 1'b1;
    tx_req     = 1'b1;
    wait_cycles(SETTLE_CYC);
    check_stall();
    hold_valid = 1'b0;
    ret_en     = 1'b1;
    bsend_en   = 1'b1;
    while (aw_acc < NUM_TXN) @(posedge clk_wr);
    traffic_en = 1'b0;
    bsend_en   = 1'b0;
    while (aw_exp.size() != 0 || w_exp.size() != 0 || user_awvalid || user_wvalid ||
           b_exp.size() != 0 || b_avail != `B_FIFO_DEPTH) @(posedge clk_wr);
    wait_cycles(5);
    $display("Done: %0d value errors, %0d other errors, %0d AW, %0d W accepted",
             val_errs, oth_errs, aw_acc, w_acc);
    if (val_errs + oth_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+logic
logic/axi_link_pkg.sv
logic/sync_fifo.sv
logic/link_ctrl.sv
logic/tx_channel.sv
logic/rx_channel.sv
logic/phy_framer.sv
logic/axi_wr_master_top.sv
test/axi_wr_master_props.sv
test/tb_axi_wr_master.sv
